//--- div_cfg_pkg.sv
`default_nettype none

package div_cfg_pkg;

  // The whole arithmetic unit is sized from the operand width.
  localparam int DATA_W = 8;

  // The working register holds the partial remainder on top of the dividend bits.
  localparam int ACC_W = 2 * DATA_W;

  localparam int CNT_W = 4; // Wide enough to reach DATA_W.

  // Operand, working register and step count words.
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ACC_W-1:0]  acc_t;
  typedef logic [CNT_W-1:0]  cnt_t;

  // Count seen during the SUB cycle of the final quotient bit.
  localparam cnt_t LAST_STEP = cnt_t'(DATA_W - 1);

  // Operands as captured on the start strobe.
  typedef struct packed {
    data_t dividend;
    data_t divisor;
  } div_operands_t;

  // A zero divisor yields an all-ones quotient and the dividend as remainder.
  typedef struct packed {
    data_t quotient;
    data_t remainder;
  } div_result_t;

endpackage : div_cfg_pkg

`default_nettype wire

//--- div_ctrl_pkg.sv
`default_nettype none

package div_ctrl_pkg;

  // One SHIFT and one SUB per quotient bit, bracketed by IDLE and DONE.
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    SHIFT = 2'd1,
    SUB   = 2'd2,
    DONE  = 2'd3
  } div_state_e;

  // Strobes from the controller to the datapath.
  // At most one of them is high in any cycle.
  typedef struct packed {
    logic load;    // Capture dividend and divisor.
    logic shift;   // Shift the working register left by one.
    logic sub;     // Compare and conditionally subtract.
    logic capture; // Copy the working register into the result.
  } div_ctrl_t;

  // Value with every strobe low.
  localparam div_ctrl_t CTRL_IDLE = '{
    load:    1'b0,
    shift:   1'b0,
    sub:     1'b0,
    capture: 1'b0
  };

endpackage : div_ctrl_pkg

`default_nettype wire

//--- div_step_counter.sv
`timescale 1ns/1ps
`default_nettype none

// Iteration timer for the SHIFT/SUB loop.
module div_step_counter
  import div_cfg_pkg::*;
(
  input  logic clk,
  input  logic rstn,
  input  logic clear,
  input  logic step,
  output logic last
);

  cnt_t cnt_q;
  cnt_t cnt_d;

  // Clear wins over step, though the controller never raises both together.
  always_comb begin
    cnt_d = cnt_q;
    if (clear) begin
      cnt_d = '0;
    end else if (step) begin
      cnt_d = cnt_q + cnt_t'(1);
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // High for the whole SUB cycle of the final bit.
  assign last = (cnt_q == LAST_STEP);

endmodule : div_step_counter

`default_nettype wire

//--- div_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

// Sequencer for the restoring divider.
// A start strobe seen in IDLE runs DATA_W pairs of SHIFT and SUB, then one DONE cycle.
module div_ctrl_fsm
  import div_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  logic      en,
  input  logic      last,
  output div_ctrl_t ctrl,
  output logic      cnt_clear,
  output logic      cnt_step,
  output logic      ready,
  output logic      vld_out
);

  div_state_e state_q;
  div_state_e state_d;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Next state.
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (en) begin
          state_d = SHIFT; // Operands are taken on this same edge.
        end
      end
      SHIFT: begin
        state_d = SUB;
      end
      SUB: begin
        if (last) begin
          state_d = DONE;
        end else begin
          state_d = SHIFT;
        end
      end
      DONE: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // Each strobe follows the current state and load also needs en.
  // A strobe raised while busy never reaches the datapath.
  always_comb begin
    ctrl      = CTRL_IDLE;
    cnt_clear = 1'b0;
    cnt_step  = 1'b0;
    case (state_q)
      IDLE: begin
        ctrl.load = en;
        cnt_clear = 1'b1; // Keeps the counter at zero while waiting.
      end
      SHIFT: begin
        ctrl.shift = 1'b1;
      end
      SUB: begin
        ctrl.sub = 1'b1;
        cnt_step = 1'b1;
      end
      DONE: begin
        ctrl.capture = 1'b1;
      end
      default: begin
        ctrl = CTRL_IDLE;
      end
    endcase
  end

  assign ready   = (state_q == IDLE);
  assign vld_out = (state_q == DONE); // One cycle, since DONE always returns to IDLE.

endmodule : div_ctrl_fsm

`default_nettype wire

//--- div_datapath.sv
`timescale 1ns/1ps
`default_nettype none

// Working register, compare-and-subtract and the result register.
module div_datapath
  import div_cfg_pkg::*;
  import div_ctrl_pkg::*;
(
  input  logic          clk,
  input  logic          rstn,
  input  div_ctrl_t     ctrl,
  input  div_operands_t operands,
  output div_result_t   result
);

  acc_t        acc_q;
  data_t       divisor_q;
  div_result_t result_q;

  data_t part_rem;
  data_t diff;
  logic  fits;

  // The upper half is the partial remainder.
  // It cannot overflow, because before the final shift it holds at most DATA_W-1 bits.
  assign part_rem = acc_q[ACC_W-1:DATA_W];
  assign fits     = (part_rem >= divisor_q);
  assign diff     = part_rem - divisor_q;

  // Working register and divisor, both loaded on the start strobe.
  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      acc_q     <= {data_t'(0), operands.dividend};
      divisor_q <= operands.divisor;
    end else if (ctrl.shift) begin
      acc_q <= {acc_q[ACC_W-2:0], 1'b0};
    end else if (ctrl.sub) begin
      if (fits) begin
        // The quotient bit lands in the zero that the shift brought in.
        acc_q <= {diff, acc_q[DATA_W-1:1], 1'b1};
      end
    end
  end

  // The result holds from one capture to the next.
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      result_q <= '0;
    end else if (ctrl.capture) begin
      result_q.quotient  <= acc_q[DATA_W-1:0];
      result_q.remainder <= part_rem;
    end
  end

  assign result = result_q;

endmodule : div_datapath

`default_nettype wire

//--- radix2_div.sv
`timescale 1ns/1ps
`default_nettype none

// Sequential unsigned radix-2 restoring divider.
// A division takes 2*DATA_W+1 cycles from the start strobe until ready is high again.
module radix2_div
  import div_cfg_pkg::*;
  import div_ctrl_pkg::*;
(
  input  logic          clk,
  input  logic          rstn,
  input  logic          en,
  input  div_operands_t operands,
  output logic          ready,
  output logic          vld_out,
  output div_result_t   result
);

  div_ctrl_t ctrl;
  logic      cnt_clear;
  logic      cnt_step;
  logic      last;

  div_ctrl_fsm ctrl_fsm_i (
    .clk       (clk),
    .rstn      (rstn),
    .en        (en),
    .last      (last),
    .ctrl      (ctrl),
    .cnt_clear (cnt_clear),
    .cnt_step  (cnt_step),
    .ready     (ready),
    .vld_out   (vld_out)
  );

  // Tells the controller when the SHIFT/SUB loop is complete.
  div_step_counter step_counter_i (
    .clk   (clk),
    .rstn  (rstn),
    .clear (cnt_clear),
    .step  (cnt_step),
    .last  (last)
  );

  div_datapath datapath_i (
    .clk      (clk),
    .rstn     (rstn),
    .ctrl     (ctrl),
    .operands (operands),
    .result   (result)
  );

endmodule : radix2_div

`default_nettype wire

//--- tb_radix2_div.sv
`timescale 1ns/1ps
`default_nettype none

module tb_radix2_div
  import div_cfg_pkg::*;
();

  localparam int NUM_FIXED   = 7;
  localparam int NUM_RANDOM  = 10;
  localparam int NUM_ENTRIES = NUM_FIXED + NUM_RANDOM;
  localparam int LATENCY     = 2 * DATA_W + 1; // Falling edges from the strobe to vld_out.
  localparam int TIMEOUT     = 4 * LATENCY;

  logic          clk;
  logic          rstn;
  logic          en;
  div_operands_t operands;
  logic          ready;
  logic          vld_out;
  div_result_t   result;

  string         name_tab [NUM_ENTRIES];
  div_operands_t ops_tab  [NUM_ENTRIES];
  div_result_t   exp_tab  [NUM_ENTRIES];
  int            num_used;
  div_result_t   prev_result;
  integer        seed;

  radix2_div dut_i (
    .clk      (clk),
    .rstn     (rstn),
    .en       (en),
    .operands (operands),
    .ready    (ready),
    .vld_out  (vld_out),
    .result   (result)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
      $display("Test failed");
      $fatal(1, "value check failed");
    end
  endtask

  // Quotient and remainder as the unsigned rule defines them.
  function automatic div_result_t rule_result(input div_operands_t op);
    div_result_t r;
    if (op.divisor == '0) begin
      r.quotient  = '1;
      r.remainder = op.dividend;
    end else begin
      r.quotient  = op.dividend / op.divisor;
      r.remainder = op.dividend % op.divisor;
    end
    return r;
  endfunction

  task automatic add_entry(input string name, input data_t dividend, input data_t divisor,
                           input data_t quotient, input data_t remainder);
    name_tab[num_used]           = name;
    ops_tab[num_used].dividend   = dividend;
    ops_tab[num_used].divisor    = divisor;
    exp_tab[num_used].quotient   = quotient;
    exp_tab[num_used].remainder  = remainder;
    num_used++;
  endtask

  task automatic build_table();
    div_operands_t op;
    div_result_t   r;
    add_entry("zero_by_one", 8'd0, 8'd1, 8'd0, 8'd0);
    add_entry("max_by_one", 8'd255, 8'd1, 8'd255, 8'd0);
    add_entry("max_by_max", 8'd255, 8'd255, 8'd1, 8'd0);
    add_entry("small_by_larger", 8'd7, 8'd9, 8'd0, 8'd7);
    add_entry("200_by_7", 8'd200, 8'd7, 8'd28, 8'd4);
    add_entry("one_by_zero", 8'd1, 8'd0, 8'd255, 8'd1); // Zero divisor gives all ones.
    add_entry("zero_by_zero", 8'd0, 8'd0, 8'd255, 8'd0);
    for (int i = 0; i < NUM_RANDOM; i++) begin
      op.dividend = data_t'($random(seed));
      op.divisor  = data_t'($random(seed));
      r = rule_result(op);
      add_entry($sformatf("random_%0d", i), op.dividend, op.divisor, r.quotient, r.remainder);
    end
  endtask

  // Called on a falling edge; returns on the first falling edge with ready high.
  task automatic wait_ready(input string name);
    int waited;
    waited = 0;
    while (!ready) begin
      if (waited == TIMEOUT) begin
        $display("ERROR %s: ready never rose within %0d cycles", name, TIMEOUT);
        $display("Test failed");
        $fatal(1, "timeout waiting for ready");
      end else begin
        @(negedge clk);
        waited++;
      end
    end
  endtask

  task automatic run_division(input int idx);
    string name;
    int    cycles;
    name = name_tab[idx];
    wait_ready(name);
    operands = ops_tab[idx];
    en       = 1'b1;
    check_value({name, " held result at start"}, 32'(prev_result), 32'(result));
    @(negedge clk);
    en     = 1'b0;
    cycles = 1;
    while (!vld_out) begin
      check_value({name, " ready while busy"}, 32'd0, 32'(ready));
      check_value({name, " held result while busy"}, 32'(prev_result), 32'(result));
      // New operands and a stray strobe mid-division must be ignored.
      if (cycles == 3) begin
        operands = ~ops_tab[idx];
        en       = 1'b1;
      end else begin
        en = 1'b0;
      end
      if (cycles == TIMEOUT) begin
        $display("ERROR %s: vld_out never pulsed within %0d cycles", name, TIMEOUT);
        $display("Test failed");
        $fatal(1, "timeout waiting for vld_out");
      end else begin
        @(negedge clk);
        cycles++;
      end
    end
    check_value({name, " latency"}, 32'(LATENCY), 32'(cycles));
    check_value({name, " ready during vld_out"}, 32'd0, 32'(ready));
    check_value({name, " result before capture"}, 32'(prev_result), 32'(result));
    @(negedge clk);
    check_value({name, " vld_out width"}, 32'd0, 32'(vld_out));
    check_value({name, " ready after done"}, 32'd1, 32'(ready));
    check_value({name, " quotient"}, 32'(exp_tab[idx].quotient), 32'(result.quotient));
    check_value({name, " remainder"}, 32'(exp_tab[idx].remainder), 32'(result.remainder));
    prev_result = exp_tab[idx];
  endtask

  initial begin
    rstn        = 1'b0;
    en          = 1'b0;
    operands    = '0;
    seed        = 83;
    num_used    = 0;
    prev_result = '0;
    build_table();

    repeat (2) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);
    check_value("reset ready", 32'd1, 32'(ready));
    check_value("reset vld_out", 32'd0, 32'(vld_out));
    check_value("reset result", 32'd0, 32'(result));

    // Each division starts on the first falling edge with ready high again.
    for (int i = 0; i < num_used; i++) begin
      run_division(i);
    end

    // Nothing may start on its own once the table is done.
    for (int i = 0; i < LATENCY; i++) begin
      @(negedge clk);
      check_value("idle vld_out", 32'd0, 32'(vld_out));
      check_value("idle ready", 32'd1, 32'(ready));
      check_value("idle result", 32'(prev_result), 32'(result));
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule : tb_radix2_div

`default_nettype wire

//--- build.f
div_cfg_pkg.sv
div_ctrl_pkg.sv
div_step_counter.sv
div_ctrl_fsm.sv
div_datapath.sv
radix2_div.sv
tb_radix2_div.sv

//--- Makefile
SRCS = div_cfg_pkg.sv div_ctrl_pkg.sv div_step_counter.sv div_ctrl_fsm.sv \
       div_datapath.sv radix2_div.sv tb_radix2_div.sv

.PHONY: all run clean

all: run

# The simulator is rebuilt only when a source or the file list changes.
obj_dir/Vtb_radix2_div: build.f $(SRCS)
	verilator --binary --timing --top-module tb_radix2_div -f build.f -o Vtb_radix2_div

run: obj_dir/Vtb_radix2_div
	./obj_dir/Vtb_radix2_div > sim.log 2>&1; cat sim.log
	@grep -q "Test completed successfully" sim.log && echo "PASS" || \
		(echo "FAIL: see sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
